/* bench/scif_rx_tb.sv */
// ------------------------------------------------------------
// SCIF receiver testbench
// Table-driven frames on the serial line, checked at the FIFO
// ------------------------------------------------------------

`include "scif_macros.svh"

`timescale 1ns/1ps

module scif_rx_tb;

	typedef struct packed {
		scif_cfg_pkg::data_len_e len;
		logic                    par_en;
		logic                    par_bad;
		logic [`SCIF_DIV_W-1:0]  div;
		logic                    hold_ready;
		logic                    en;
		logic [7:0]              frames;
	} entry_t;

	localparam int N_ENTRIES = 15;
	localparam int DEPTH     = `SCIF_FIFO_DEPTH;

	// Length, parity, bad parity, div, ready low, enable, frames
	localparam entry_t STIM [N_ENTRIES] = '{
		'{scif_cfg_pkg::LEN_5, 1'b0, 1'b0, 16'd3, 1'b0, 1'b1, 8'd4},
		'{scif_cfg_pkg::LEN_6, 1'b0, 1'b0, 16'd3, 1'b0, 1'b1, 8'd4},
		'{scif_cfg_pkg::LEN_7, 1'b0, 1'b0, 16'd3, 1'b0, 1'b1, 8'd4},
		'{scif_cfg_pkg::LEN_8, 1'b0, 1'b0, 16'd3, 1'b0, 1'b1, 8'd4},
		'{scif_cfg_pkg::LEN_5, 1'b0, 1'b0, 16'd10, 1'b0, 1'b1, 8'd3},
		'{scif_cfg_pkg::LEN_6, 1'b0, 1'b0, 16'd10, 1'b0, 1'b1, 8'd3},
		'{scif_cfg_pkg::LEN_7, 1'b0, 1'b0, 16'd10, 1'b0, 1'b1, 8'd3},
		'{scif_cfg_pkg::LEN_8, 1'b0, 1'b0, 16'd10, 1'b0, 1'b1, 8'd3},
		'{scif_cfg_pkg::LEN_8, 1'b1, 1'b0, 16'd5, 1'b0, 1'b1, 8'd4},
		'{scif_cfg_pkg::LEN_7, 1'b1, 1'b0, 16'd7, 1'b0, 1'b1, 8'd3},
		'{scif_cfg_pkg::LEN_8, 1'b1, 1'b1, 16'd5, 1'b0, 1'b1, 8'd3},
		'{scif_cfg_pkg::LEN_6, 1'b1, 1'b1, 16'd4, 1'b0, 1'b1, 8'd2},
		'{scif_cfg_pkg::LEN_8, 1'b0, 1'b0, 16'd4, 1'b1, 1'b1, 8'(`SCIF_FIFO_DEPTH + 2)},
		'{scif_cfg_pkg::LEN_8, 1'b0, 1'b0, 16'd4, 1'b0, 1'b0, 8'd3},
		'{scif_cfg_pkg::LEN_8, 1'b0, 1'b0, 16'd3, 1'b0, 1'b1, 8'd8}
	};

	logic                      clk = 1'b0;
	logic                      rstn;
	logic                      rx_line;
	logic                      rx_ready;
	scif_cfg_pkg::line_cfg_t   cfg;
	scif_data_pkg::rx_char_t   rx_data;
	logic                      rx_valid;
	scif_data_pkg::rx_status_t status;
	logic                      busy;

	logic [31:0]             lfsr_q = 32'hdf4a806e;
	scif_data_pkg::rx_char_t exp_q [$];
	scif_data_pkg::rx_char_t got_q [$];

	int done_cnt  = 0;
	int perr_cnt  = 0;
	int ovf_cnt   = 0;
	int busy_cnt  = 0;
	int err_cnt   = 0;
	int check_cnt = 0;

	always #5 clk = ~clk;

	scif_rx_top UUT (
		.clk_i      (clk),
		.rstn_i     (rstn),
		.rx_i       (rx_line),
		.cfg_i      (cfg),
		.rx_data_o  (rx_data),
		.rx_valid_o (rx_valid),
		.rx_ready_i (rx_ready),
		.status_o   (status),
		.busy_o     (busy)
	);

	// Collects every FIFO transfer and counts the status pulses
	always @(posedge clk)
	begin
		if (rstn)
		begin
			if (rx_valid && rx_ready)
				got_q.push_back(rx_data);
			if (status.char_done)
				done_cnt++;
			if (status.parity_err)
				perr_cnt++;
			if (status.overflow)
				ovf_cnt++;
			if (busy)
				busy_cnt++;
		end
	end

	// Galois form where the low bit is the one taken before each step
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	task automatic check_value(input string what, input int got, input int exp);
		check_cnt++;
		if (got != exp)
		begin
			err_cnt++;
			$display("[ERROR] %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic send_bit(input logic value, input int div);
		rx_line = value;
		repeat (div + 1) @(negedge clk);
	endtask

	task automatic drive_frame(input logic [7:0] data, input int nbits, input logic par_en,
		input logic par_bad, input int div);
		int   b;
		logic par;
		// Even parity that is inverted on request to provoke an error
		par = (^data) ^ par_bad;
		send_bit(1'b0, div);
		for (b = 0; b < nbits; b++)
			send_bit(data[b], div);
		if (par_en)
			send_bit(par, div);
		send_bit(1'b1, div);
	endtask

	task automatic run_entry(input int idx, input entry_t t);
		int         nbits;
		int         f;
		int         b;
		int         k;
		int         n_new;
		int         exp_done;
		int         exp_perr;
		int         exp_ovf;
		int         base_done;
		int         base_perr;
		int         base_ovf;
		int         base_busy;
		int         base_got;
		int         base_exp;
		logic [7:0] data;
		logic [7:0] mask;
		nbits         = 5 + int'(t.len);
		mask          = 8'hff >> (8 - nbits);
		cfg.en        = t.en;
		cfg.parity_en = t.par_en;
		cfg.data_len  = t.len;
		cfg.div       = t.div;
		rx_ready      = ~t.hold_ready;
		@(negedge clk);
		base_done = done_cnt;
		base_perr = perr_cnt;
		base_ovf  = ovf_cnt;
		base_busy = busy_cnt;
		base_got  = got_q.size();
		base_exp  = exp_q.size();
		exp_done  = 0;
		exp_perr  = 0;
		exp_ovf   = 0;
		for (f = 0; f < int'(t.frames); f++)
		begin
			data = '0;
			for (b = 0; b < nbits; b++)
			begin
				data[b] = lfsr_q[0];
				lfsr_q  = lfsr_step(lfsr_q);
			end
			if (t.en)
			begin
				if (t.par_en && t.par_bad)
					exp_perr++;
				else if (t.hold_ready && f >= DEPTH)
					exp_ovf++;
				else
				begin
					exp_done++;
					exp_q.push_back(data & mask);
				end
			end
			drive_frame(data, nbits, t.par_en, t.par_bad, t.div);
		end
		// The stop sample lies inside the last stop bit and busy drops right after it
		for (k = 0; k < int'(t.div) + 1 && busy; k++)
			@(negedge clk);
		check_value($sformatf("entry %0d busy after last frame", idx), busy, 0);
		repeat (4) @(negedge clk);
		// Releasing ready drains whatever piled up in the FIFO
		rx_ready = 1'b1;
		while (got_q.size() - base_got < exp_q.size() - base_exp)
			@(negedge clk);
		repeat (4) @(negedge clk);
		n_new = got_q.size() - base_got;
		check_value($sformatf("entry %0d character count", idx), n_new, exp_q.size() - base_exp);
		for (k = 0; k < n_new && base_exp + k < exp_q.size(); k++)
			check_value($sformatf("entry %0d character %0d", idx, k), got_q[base_got + k],
				exp_q[base_exp + k]);
		check_value($sformatf("entry %0d char_done pulses", idx), done_cnt - base_done, exp_done);
		check_value($sformatf("entry %0d parity_err pulses", idx), perr_cnt - base_perr, exp_perr);
		check_value($sformatf("entry %0d overflow pulses", idx), ovf_cnt - base_ovf, exp_ovf);
		if (!t.en)
			check_value($sformatf("entry %0d busy cycles", idx), busy_cnt - base_busy, 0);
	endtask

	initial
	begin
		int e;
		rstn     = 1'b0;
		rx_line  = 1'b1;
		rx_ready = 1'b1;
		cfg      = '{1'b1, 1'b0, scif_cfg_pkg::LEN_8, 16'd3};
		repeat (10) @(negedge clk);
		rstn = 1'b1;
		repeat (5) @(negedge clk);
		for (e = 0; e < N_ENTRIES; e++)
			run_entry(e, STIM[e]);
		$display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Worst case is eleven bits per frame plus settling time per entry
	initial
	begin
		longint cycles;
		int     e;
		cycles = 100;
		for (e = 0; e < N_ENTRIES; e++)
			cycles += longint'(STIM[e].frames) * 11 * (longint'(STIM[e].div) + 1) + 500;
		#(cycles * 10);
		$display("Timeout: the tests did not finish within %0d clock cycles", cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* compile.f */
+incdir+source
source/scif_cfg_pkg.sv
source/scif_data_pkg.sv
source/scif_baud_timer.sv
source/scif_rx_datapath.sv
source/scif_rx_fsm.sv
source/scif_rx_fifo.sv
source/scif_rx_top.sv
bench/scif_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the SCIF receiver testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f compile.f --top-module scif_rx_tb -o scif_rx_sim
./obj_dir/scif_rx_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi

/* source/scif_baud_timer.sv */
// ------------------------------------------------------------
// SCIF baud timer
// Counts clocks per bit and flags the sample points
// ------------------------------------------------------------

`include "scif_macros.svh"

`timescale 1ns/1ps

module scif_baud_timer (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic [`SCIF_DIV_W-1:0] div_i,
	input  logic                   run_i,
	input  logic                   half_i,
	output logic                   bit_done_o
);

	logic [`SCIF_DIV_W-1:0] cnt_q;
	logic [`SCIF_DIV_W-1:0] target;

	// Half the period puts the first sample in the middle of the start bit
	assign target = half_i ? {1'b0, div_i[`SCIF_DIV_W-1:1]} : div_i;

	assign bit_done_o = run_i && (cnt_q == target);

	always_ff @(posedge clk_i or negedge rstn_i)
	begin
		if (!rstn_i)
		begin
			cnt_q <= '0;
		end
		else if (!run_i || bit_done_o)
		begin
			cnt_q <= '0;
		end
		else
		begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

endmodule

/* source/scif_cfg_pkg.sv */
// ------------------------------------------------------------
// SCIF line configuration types
// Data-length code and the line configuration struct
// ------------------------------------------------------------

`include "scif_macros.svh"

package scif_cfg_pkg;

	// Number of data bits per character
	typedef enum logic [1:0] {
		LEN_5 = 2'b00,
		LEN_6 = 2'b01,
		LEN_7 = 2'b10,
		LEN_8 = 2'b11
	} data_len_e;

	typedef struct packed {
		logic                   en;
		logic                   parity_en;
		data_len_e              data_len;
		logic [`SCIF_DIV_W-1:0] div;
	} line_cfg_t;

endpackage

/* source/scif_data_pkg.sv */
// ------------------------------------------------------------
// SCIF receive data types
// Received character, status pulses and frame control
// ------------------------------------------------------------

package scif_data_pkg;

	// Right-aligned character, unused upper bits are zero
	typedef logic [7:0] rx_char_t;

	typedef struct packed {
		logic char_done;
		logic parity_err;
		logic overflow;
	} rx_status_t;

	typedef struct packed {
		logic clear;
		logic shift;
		logic check;
	} frame_ctl_t;

endpackage

/* source/scif_macros.svh */
// ------------------------------------------------------------
// SCIF receiver build-time sizes
// Divider width and receive FIFO depth
// ------------------------------------------------------------

`ifndef SCIF_MACROS_SVH
`define SCIF_MACROS_SVH

// Width of the baud divider, one bit lasts div plus one clocks
`define SCIF_DIV_W 16

// Number of characters the receive FIFO can hold
`define SCIF_FIFO_DEPTH 4

`endif

/* source/scif_rx_datapath.sv */
// ------------------------------------------------------------
// SCIF receive data path
// Line synchronizer, start-edge detect, shifter and parity
// ------------------------------------------------------------

`timescale 1ns/1ps

module scif_rx_datapath (
	input  logic                    clk_i,
	input  logic                    rstn_i,
	input  logic                    rx_i,
	input  scif_cfg_pkg::line_cfg_t cfg_i,
	input  scif_data_pkg::frame_ctl_t ctl_i,
	output logic                    rx_fall_o,
	output logic                    bit_o,
	output logic                    parity_ok_o,
	output scif_data_pkg::rx_char_t data_o
);

	// Two synchronizer stages plus one delayed copy for the edge detect
	logic [2:0] sync_q;
	logic       parity_q;
	logic [2:0] msb;

	scif_data_pkg::rx_char_t shift_q;
	scif_data_pkg::rx_char_t shift_d;

	always_ff @(posedge clk_i or negedge rstn_i)
	begin
		if (!rstn_i)
			sync_q <= 3'b111;
		else if (!cfg_i.en)
			sync_q <= 3'b111;
		else
			sync_q <= {sync_q[1:0], rx_i};
	end

	assign bit_o     = sync_q[1];
	assign rx_fall_o = sync_q[2] & ~sync_q[1];

	// New bits enter at the top of the configured width and move down
	assign msb = 3'd4 + {1'b0, cfg_i.data_len};

	always_comb
	begin
		shift_d      = shift_q >> 1;
		shift_d[msb] = bit_o;
	end

	always_ff @(posedge clk_i)
	begin
		if (ctl_i.clear)
			shift_q <= '0;
		else if (ctl_i.shift)
			shift_q <= shift_d;
	end

	// Even parity over the data bits taken so far
	always_ff @(posedge clk_i or negedge rstn_i)
	begin
		if (!rstn_i)
			parity_q <= 1'b0;
		else if (ctl_i.clear)
			parity_q <= 1'b0;
		else if (ctl_i.shift)
			parity_q <= parity_q ^ bit_o;
	end

	assign parity_ok_o = ctl_i.check && (bit_o == parity_q);
	assign data_o      = shift_q;

endmodule

/* source/scif_rx_fifo.sv */
// ------------------------------------------------------------
// SCIF receive FIFO
// Circular buffer with valid/ready on both sides
// ------------------------------------------------------------

`include "scif_macros.svh"

`timescale 1ns/1ps

module scif_rx_fifo (
	input  logic                    clk_i,
	input  logic                    rstn_i,
	input  logic                    wr_valid_i,
	output logic                    wr_ready_o,
	input  scif_data_pkg::rx_char_t wr_data_i,
	output logic                    rd_valid_o,
	input  logic                    rd_ready_i,
	output scif_data_pkg::rx_char_t rd_data_o
);

	localparam int DEPTH = `SCIF_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	scif_data_pkg::rx_char_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             wr_en;
	logic             rd_en;

	assign wr_ready_o = (count_q != CNT_W'(DEPTH));
	assign rd_valid_o = (count_q != '0);
	assign rd_data_o  = mem[rd_ptr_q];

	assign wr_en = wr_valid_i && wr_ready_o;
	assign rd_en = rd_valid_o && rd_ready_i;

	always_ff @(posedge clk_i)
	begin
		if (wr_en)
			mem[wr_ptr_q] <= wr_data_i;
	end

	always_ff @(posedge clk_i or negedge rstn_i)
	begin
		if (!rstn_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (rd_en)
				rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			// Simultaneous read and write leave the count unchanged
			if (wr_en && !rd_en)
				count_q <= count_q + 1'b1;
			else if (rd_en && !wr_en)
				count_q <= count_q - 1'b1;
		end
	end

endmodule

/* source/scif_rx_fsm.sv */
// ------------------------------------------------------------
// SCIF receive frame state machine
// Walks start, data, parity and stop and posts characters
// ------------------------------------------------------------

`timescale 1ns/1ps

module scif_rx_fsm (
	input  logic                      clk_i,
	input  logic                      rstn_i,
	input  scif_cfg_pkg::line_cfg_t   cfg_i,
	input  logic                      rx_fall_i,
	input  logic                      bit_i,
	input  logic                      bit_done_i,
	input  logic                      parity_ok_i,
	output logic                      run_o,
	output logic                      half_o,
	output scif_data_pkg::frame_ctl_t ctl_o,
	output logic                      char_valid_o,
	input  logic                      char_ready_i,
	output scif_data_pkg::rx_status_t status_o,
	output logic                      busy_o
);

	typedef enum logic [2:0] {
		IDLE,
		START,
		DATA,
		PARITY,
		STOP
	} state_e;

	state_e     state_q;
	state_e     state_d;
	logic [2:0] bit_cnt_q;
	logic [2:0] bit_cnt_d;
	logic [2:0] last_bit;
	logic       par_err_q;
	logic       par_err_d;

	// Index of the final data bit, 4 for five bits up to 7 for eight
	assign last_bit = 3'd4 + {1'b0, cfg_i.data_len};

	always_comb
	begin
		state_d      = state_q;
		bit_cnt_d    = bit_cnt_q;
		par_err_d    = par_err_q;
		run_o        = 1'b0;
		half_o       = 1'b0;
		ctl_o        = '0;
		char_valid_o = 1'b0;
		status_o     = '0;

		if (cfg_i.en)
		begin
			run_o = (state_q != IDLE);
			case (state_q)
				IDLE:
				begin
					if (rx_fall_i)
					begin
						ctl_o.clear = 1'b1;
						bit_cnt_d   = '0;
						par_err_d   = 1'b0;
						state_d     = START;
					end
				end
				START:
				begin
					half_o = 1'b1;
					// A line that is high again at mid-bit was only a glitch
					if (bit_done_i)
						state_d = bit_i ? IDLE : DATA;
				end
				DATA:
				begin
					if (bit_done_i)
					begin
						ctl_o.shift = 1'b1;
						if (bit_cnt_q == last_bit)
						begin
							bit_cnt_d = '0;
							state_d   = cfg_i.parity_en ? PARITY : STOP;
						end
						else
						begin
							bit_cnt_d = bit_cnt_q + 1'b1;
						end
					end
				end
				PARITY:
				begin
					if (bit_done_i)
					begin
						ctl_o.check = 1'b1;
						if (!parity_ok_i)
							par_err_d = 1'b1;
						state_d = STOP;
					end
				end
				STOP:
				begin
					if (bit_done_i)
					begin
						state_d = IDLE;
						if (par_err_q)
						begin
							status_o.parity_err = 1'b1;
						end
						else
						begin
							// The FIFO gets exactly one chance to take the character
							char_valid_o       = 1'b1;
							status_o.char_done = char_ready_i;
							status_o.overflow  = !char_ready_i;
						end
					end
				end
				default:
				begin
					state_d = IDLE;
				end
			endcase
		end
	end

	assign busy_o = run_o;

	always_ff @(posedge clk_i or negedge rstn_i)
	begin
		if (!rstn_i)
		begin
			state_q   <= IDLE;
			bit_cnt_q <= '0;
			par_err_q <= 1'b0;
		end
		else if (!cfg_i.en)
		begin
			state_q   <= IDLE;
			bit_cnt_q <= '0;
			par_err_q <= 1'b0;
		end
		else
		begin
			state_q   <= state_d;
			bit_cnt_q <= bit_cnt_d;
			par_err_q <= par_err_d;
		end
	end

endmodule

/* source/scif_rx_top.sv */
// ------------------------------------------------------------
// SCIF receiver top level
// Timer, data path, frame FSM and receive FIFO
// ------------------------------------------------------------

`timescale 1ns/1ps

module scif_rx_top (
	input  logic                      clk_i,
	input  logic                      rstn_i,
	input  logic                      rx_i,
	input  scif_cfg_pkg::line_cfg_t   cfg_i,
	output scif_data_pkg::rx_char_t   rx_data_o,
	output logic                      rx_valid_o,
	input  logic                      rx_ready_i,
	output scif_data_pkg::rx_status_t status_o,
	output logic                      busy_o
);

	logic rx_fall;
	logic line_bit;
	logic bit_done;
	logic parity_ok;
	logic run;
	logic half;
	logic char_valid;
	logic char_ready;

	scif_data_pkg::frame_ctl_t frame_ctl;
	scif_data_pkg::rx_char_t   char_data;

	scif_baud_timer i_timer (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.div_i      (cfg_i.div),
		.run_i      (run),
		.half_i     (half),
		.bit_done_o (bit_done)
	);

	scif_rx_datapath i_datapath (
		.clk_i       (clk_i),
		.rstn_i      (rstn_i),
		.rx_i        (rx_i),
		.cfg_i       (cfg_i),
		.ctl_i       (frame_ctl),
		.rx_fall_o   (rx_fall),
		.bit_o       (line_bit),
		.parity_ok_o (parity_ok),
		.data_o      (char_data)
	);

	scif_rx_fsm i_fsm (
		.clk_i        (clk_i),
		.rstn_i       (rstn_i),
		.cfg_i        (cfg_i),
		.rx_fall_i    (rx_fall),
		.bit_i        (line_bit),
		.bit_done_i   (bit_done),
		.parity_ok_i  (parity_ok),
		.run_o        (run),
		.half_o       (half),
		.ctl_o        (frame_ctl),
		.char_valid_o (char_valid),
		.char_ready_i (char_ready),
		.status_o     (status_o),
		.busy_o       (busy_o)
	);

	scif_rx_fifo i_fifo (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.wr_valid_i (char_valid),
		.wr_ready_o (char_ready),
		.wr_data_i  (char_data),
		.rd_valid_o (rx_valid_o),
		.rd_ready_i (rx_ready_i),
		.rd_data_o  (rx_data_o)
	);

endmodule
